//--- all.f
+incdir+.
bus_pkg.sv
rv_pkg.sv
axi_r_if.sv
fetch_if.sv
ifu.sv
imem.sv
next_pc_unit.sv
fetch_top.sv
tb_fetch.sv

//--- axi_r_if.sv
`default_nettype none

interface axi_r_if import bus_pkg::*; ();

  // read address channel
  logic      arvalid;
  logic      arready;
  bus_addr_t araddr;

  // read data channel
  logic      rvalid;
  logic      rready;
  bus_data_t rdata;
  axi_resp_t rresp;

  modport master (
    output arvalid, araddr, rready,
    input  arready, rvalid, rdata, rresp
  );

  modport slave (
    input  arvalid, araddr, rready,
    output arready, rvalid, rdata, rresp
  );

endinterface

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none
`include "fetch_cfg.svh"

package bus_pkg;

  // read channel address and data
  typedef logic [`FETCH_XLEN-1:0] bus_addr_t;
  typedef logic [`FETCH_XLEN-1:0] bus_data_t;

  // rresp encoding, only OKAY (2'b00) is ever returned
  typedef logic [1:0] axi_resp_t;

endpackage

`default_nettype wire

//--- fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first fetch address once reset is released
`define FETCH_RESET_PC 32'h80000000

// word and address width
`define FETCH_XLEN 32

// instruction memory size in 32-bit words
`define IMEM_DEPTH 256

// upper bound on cycles from address accept to rvalid
`define IMEM_LAT_MAX 4

`endif

//--- fetch_if.sv
`default_nettype none

interface fetch_if import rv_pkg::*; ();

  logic  valid;
  logic  ready;
  pc_t   pc;
  inst_t inst;

  modport producer (
    output valid, pc, inst,
    input  ready
  );

  modport consumer (
    input  valid, pc, inst,
    output ready
  );

endinterface

`default_nettype wire

//--- fetch_tests.txt
# M <byte address> <word> preloads memory, T <name> <retires> opens a test
# E <pc> <instruction> is one expected retire, listed in retire order
T reset_seq 5
M 80000000 00100093
M 80000004 00208113
M 80000008 00310193
M 8000000c 00418213
M 80000010 0f00006f
E 80000000 00100093
E 80000004 00208113
E 80000008 00310193
E 8000000c 00418213
E 80000010 0f00006f
T fwd_jal 4
M 80000100 00500293
M 80000104 01c0006f
M 80000120 00628313
M 80000124 0dc0006f
E 80000100 00500293
E 80000104 01c0006f
E 80000120 00628313
E 80000124 0dc0006f
T back_jal 5
M 80000200 0400006f
M 80000204 00838413
M 80000208 0f80006f
M 80000240 00700393
M 80000244 fc1ff06f
E 80000200 0400006f
E 80000240 00700393
E 80000244 fc1ff06f
E 80000204 00838413
E 80000208 0f80006f
T long_seq 8
M 80000300 00940493
M 80000304 00a50513
M 80000308 00b58593
M 8000030c 00c60613
M 80000310 00d68693
M 80000314 00e70713
M 80000318 0000006f
E 80000300 00940493
E 80000304 00a50513
E 80000308 00b58593
E 8000030c 00c60613
E 80000310 00d68693
E 80000314 00e70713
E 80000318 0000006f
E 80000318 0000006f

//--- fetch_top.sv
`default_nettype none

module fetch_top import bus_pkg::*, rv_pkg::*; (
  input  wire            clk,
  input  wire            rstn,
  // memory preload
  input  wire            load_en,
  input  wire bus_addr_t load_addr,
  input  wire bus_data_t load_data,
  // retired pc/inst pairs
  output logic           retire_valid,
  output pc_t            retire_pc,
  output inst_t          retire_inst,
  input  wire            retire_ready
);

  axi_r_if mem_bus ();
  fetch_if fetch_ch ();

  logic npc_valid;
  pc_t  npc;
  logic npc_ready;

  ifu ifu_inst (
    .clk       (clk),
    .rstn      (rstn),
    .npc_valid (npc_valid),
    .npc       (npc),
    .npc_ready (npc_ready),
    .fetch     (fetch_ch.producer),
    .mem       (mem_bus.master)
  );

  imem imem_inst (
    .clk       (clk),
    .rstn      (rstn),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .bus       (mem_bus.slave)
  );

  next_pc_unit next_pc_unit_inst (
    .clk          (clk),
    .rstn         (rstn),
    .fetch        (fetch_ch.consumer),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_inst  (retire_inst),
    .retire_ready (retire_ready),
    .npc_valid    (npc_valid),
    .npc          (npc),
    .npc_ready    (npc_ready)
  );

endmodule

`default_nettype wire

//--- ifu.sv
`default_nettype none
`include "fetch_cfg.svh"

module ifu import rv_pkg::*; (
  input  wire        clk,
  input  wire        rstn,
  // next pc from the execute side
  input  wire        npc_valid,
  input  wire pc_t   npc,
  output logic       npc_ready,
  fetch_if.producer  fetch,
  axi_r_if.master    mem
);

  // low until the reset-pc fetch has been launched
  logic  started;
  // npc parked while the address channel is busy
  logic  hold_valid;
  pc_t   hold_pc;
  // pc of the address memory has accepted
  pc_t   inflight_pc;
  // returned word waiting for the output register
  logic  skid_valid;
  pc_t   skid_pc;
  inst_t skid_inst;

  logic ar_fire;
  logic r_fire;
  logic npc_fire;
  logic ar_free;
  logic out_free;

  assign ar_fire  = mem.arvalid & mem.arready;
  assign r_fire   = mem.rvalid & mem.rready;
  assign npc_fire = npc_valid & npc_ready;
  // address slot empty or handing off this cycle
  assign ar_free  = ~mem.arvalid | ar_fire;
  // output register empty or draining this cycle
  assign out_free = ~fetch.valid | fetch.ready;

  assign npc_ready  = ~hold_valid;
  assign mem.rready = ~skid_valid;

  // address channel control
  always_ff @(posedge clk) begin
    if (!rstn) begin
      started     <= 1'b0;
      mem.arvalid <= 1'b0;
      hold_valid  <= 1'b0;
    end else begin
      started <= 1'b1;
      if (!started) begin
        mem.arvalid <= 1'b1;
      end else if (ar_free) begin
        if (hold_valid) begin
          mem.arvalid <= 1'b1;
          hold_valid  <= 1'b0;
        end else begin
          mem.arvalid <= npc_fire;
        end
      end else if (npc_fire) begin
        hold_valid <= 1'b1;
      end
    end
  end

  // address payload and pc stage registers
  always_ff @(posedge clk) begin
    if (!started) begin
      mem.araddr <= `FETCH_RESET_PC;
    end else if (ar_free) begin
      if (hold_valid) begin
        mem.araddr <= hold_pc;
      end else if (npc_fire) begin
        mem.araddr <= npc;
      end
    end
    if (npc_fire && !ar_free) begin
      hold_pc <= npc;
    end
    if (ar_fire) begin
      inflight_pc <= mem.araddr;
    end
  end

  // output and skid control
  always_ff @(posedge clk) begin
    if (!rstn) begin
      fetch.valid <= 1'b0;
      skid_valid  <= 1'b0;
    end else begin
      if (skid_valid) begin
        if (out_free) begin
          fetch.valid <= 1'b1;
          skid_valid  <= 1'b0;
        end
      end else if (r_fire) begin
        if (out_free) begin
          fetch.valid <= 1'b1;
        end else begin
          skid_valid <= 1'b1;
        end
      end else if (fetch.ready) begin
        fetch.valid <= 1'b0;
      end
    end
  end

  // pc/inst pairs, skid drains first
  always_ff @(posedge clk) begin
    if (skid_valid && out_free) begin
      fetch.pc   <= skid_pc;
      fetch.inst <= skid_inst;
    end else if (r_fire && out_free) begin
      fetch.pc   <= inflight_pc;
      fetch.inst <= mem.rdata;
    end
    if (r_fire && !out_free) begin
      skid_pc   <= inflight_pc;
      skid_inst <= mem.rdata;
    end
  end

endmodule

`default_nettype wire

//--- imem.sv
`default_nettype none
`include "fetch_cfg.svh"

module imem import bus_pkg::*; (
  input  wire            clk,
  input  wire            rstn,
  // preload port
  input  wire            load_en,
  input  wire bus_addr_t load_addr,
  input  wire bus_data_t load_data,
  axi_r_if.slave         bus
);

  localparam int IDX_W   = $clog2(`IMEM_DEPTH);
  localparam int LAT_MAX = `IMEM_LAT_MAX;
  localparam int LAT_W   = $clog2(LAT_MAX + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_RESP
  } state_t;

  state_t           state;
  bus_data_t        mem [`IMEM_DEPTH];
  logic [IDX_W-1:0] rd_idx;
  logic [LAT_W-1:0] wait_cnt;
  logic [LAT_W-1:0] lat_pick;
  logic [7:0]       lfsr;
  logic             ar_fire;
  logic             r_fire;
  logic             data_due;

  assign ar_fire  = bus.arvalid & bus.arready;
  assign r_fire   = bus.rvalid & bus.rready;
  assign data_due = (state == S_WAIT) && (wait_cnt == LAT_W'(1));

  // one request at a time
  assign bus.arready = (state == S_IDLE);
  assign bus.rvalid  = (state == S_RESP);
  assign bus.rresp   = '0;

  // delay of 1..LAT_MAX cycles
  assign lat_pick = LAT_W'(int'(lfsr) % LAT_MAX + 1);

  // word array, byte address bits [1:0] dropped
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr[IDX_W+1:2]] <= load_data;
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk) begin
    if (!rstn) begin
      lfsr <= 8'hA5;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= S_IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (ar_fire) begin
            state    <= S_WAIT;
            wait_cnt <= lat_pick;
          end
        end
        S_WAIT: begin
          wait_cnt <= wait_cnt - LAT_W'(1);
          if (data_due) begin
            state <= S_RESP;
          end
        end
        S_RESP: begin
          if (r_fire) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // read address and returned word
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rd_idx <= bus.araddr[IDX_W+1:2];
    end
    if (data_due) begin
      bus.rdata <= mem[rd_idx];
    end
  end

endmodule

`default_nettype wire

//--- next_pc_unit.sv
`default_nettype none

module next_pc_unit import rv_pkg::*; (
  input  wire        clk,
  input  wire        rstn,
  fetch_if.consumer  fetch,
  // retire stream
  output logic       retire_valid,
  output pc_t        retire_pc,
  output inst_t      retire_inst,
  input  wire        retire_ready,
  // next pc back to the fetch unit
  output logic       npc_valid,
  output pc_t        npc,
  input  wire        npc_ready
);

  typedef enum logic [1:0] {
    S_TAKE,
    S_RETIRE,
    S_NPC
  } state_t;

  state_t  state;
  pc_t     pc_q;
  inst_t   inst_q;
  pc_t     npc_q;
  opcode_t opcode;
  pc_t     j_imm;
  pc_t     next_pc;

  assign opcode = fetch.inst[6:0];

  // J-type immediate, sign from inst[31], bit 0 always zero
  assign j_imm = {{($bits(pc_t) - 21){fetch.inst[31]}}, fetch.inst[31],
                  fetch.inst[19:12], fetch.inst[20], fetch.inst[30:21], 1'b0};

  assign next_pc = (opcode == OP_JAL) ? fetch.pc + j_imm : fetch.pc + pc_t'(4);

  assign fetch.ready  = (state == S_TAKE);
  assign retire_valid = (state == S_RETIRE);
  assign npc_valid    = (state == S_NPC);

  assign retire_pc   = pc_q;
  assign retire_inst = inst_q;
  assign npc         = npc_q;

  // one instruction in the loop at a time
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= S_TAKE;
    end else begin
      case (state)
        S_TAKE:   if (fetch.valid) state <= S_RETIRE;
        S_RETIRE: if (retire_ready) state <= S_NPC;
        S_NPC:    if (npc_ready) state <= S_TAKE;
        default:  state <= S_TAKE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetch.valid && fetch.ready) begin
      pc_q   <= fetch.pc;
      inst_q <= fetch.inst;
      npc_q  <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_fetch -f all.f \
  --Mdir obj_dir -o tb_fetch_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_fetch_sim > sim.log 2>&1
cat sim.log
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- rv_pkg.sv
`default_nettype none
`include "fetch_cfg.svh"

package rv_pkg;

  // program counter and raw instruction word
  typedef logic [`FETCH_XLEN-1:0] pc_t;
  typedef logic [`FETCH_XLEN-1:0] inst_t;

  // major opcode, inst[6:0]
  typedef logic [6:0] opcode_t;

  // jal rd, imm
  localparam opcode_t OP_JAL = 7'b1101111;

endpackage

`default_nettype wire

//--- tb_fetch.sv
`default_nettype none
`include "fetch_cfg.svh"

module tb_fetch import bus_pkg::*, rv_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int IDX_W      = $clog2(`IMEM_DEPTH);
  // extra cycles on top of the per-retire budget
  localparam int SLACK      = 200;

  logic      clk;
  logic      rstn;
  logic      load_en;
  bus_addr_t load_addr;
  bus_data_t load_data;
  logic      retire_valid;
  pc_t       retire_pc;
  inst_t     retire_inst;
  logic      retire_ready;

  // contents of fetch_tests.txt
  bus_addr_t       load_addr_q [$];
  bus_data_t       load_data_q [$];
  logic [8*24-1:0] test_name_q [$];
  int              test_len_q  [$];
  pc_t             exp_pc_q    [$];
  inst_t           exp_inst_q  [$];
  // reference copy of the preloaded words
  bus_data_t       image [`IMEM_DEPTH];

  int   errors;
  int   checked;
  int   total_retires;
  logic running;

  fetch_top fetch_top_inst (
    .clk          (clk),
    .rstn         (rstn),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_inst  (retire_inst),
    .retire_ready (retire_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // jal offset is imm[20|10:1|11|19:12] packed into inst[31:12]
  function automatic pc_t expected_next_pc(input pc_t pc, input inst_t inst);
    logic [20:0] offset;
    offset[20]    = inst[31];
    offset[10:1]  = inst[30:21];
    offset[11]    = inst[20];
    offset[19:12] = inst[19:12];
    offset[0]     = 1'b0;
    if (inst[6:0] == OP_JAL) begin
      return pc + {{11{offset[20]}}, offset};
    end else begin
      return pc + 32'd4;
    end
  endfunction

  task automatic read_tests();
    int               fd;
    int               code;
    logic [7:0]       tag;
    logic [8*24-1:0]  name;
    logic [8*120-1:0] rest;
    logic [31:0]      a;
    logic [31:0]      d;
    int               n;
    bit               done;
    fd = $fopen("fetch_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open fetch_tests.txt");
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, "%s", tag);
        if (code != 1) begin
          done = 1'b1;
        end else if (tag == "#") begin
          code = $fgets(rest, fd);
        end else if (tag == "M") begin
          code = $fscanf(fd, "%h %h", a, d);
          load_addr_q.push_back(a);
          load_data_q.push_back(d);
          image[a[IDX_W+1:2]] = d;
        end else if (tag == "T") begin
          code = $fscanf(fd, "%s %d", name, n);
          test_name_q.push_back(name);
          test_len_q.push_back(n);
          total_retires += n;
        end else if (tag == "E") begin
          code = $fscanf(fd, "%h %h", a, d);
          exp_pc_q.push_back(a);
          exp_inst_q.push_back(d);
        end else begin
          errors++;
          $display("unknown line tag %0s in fetch_tests.txt", tag);
        end
      end
      $fclose(fd);
    end
  endtask

  // wait for the next retire transfer while a stalled pair holds still
  task automatic next_retire(input logic [8*24-1:0] name, output pc_t pc, output inst_t inst);
    logic  stalled;
    pc_t   held_pc;
    inst_t held_inst;
    bit    taken;
    stalled = 1'b0;
    taken   = 1'b0;
    while (!taken) begin
      @(negedge clk);
      if (stalled) begin
        assert (retire_valid === 1'b1 && retire_pc === held_pc && retire_inst === held_inst)
        else begin
          errors++;
          $display("in %0s the retire pair was dropped or changed while stalled", name);
        end
      end
      if (retire_valid && retire_ready) begin
        taken = 1'b1;
        pc    = retire_pc;
        inst  = retire_inst;
      end else begin
        stalled   = retire_valid;
        held_pc   = retire_pc;
        held_inst = retire_inst;
      end
    end
  endtask

  initial begin
    int    idx;
    int    k;
    int    test_errors;
    pc_t   pc;
    inst_t inst;
    pc_t   want_pc;
    inst_t want_inst;
    pc_t   prev_pc;
    inst_t prev_inst;
    pc_t   rule_pc;
    void'($urandom(35815));
    rstn          <= 1'b0;
    load_en       <= 1'b0;
    load_addr     <= '0;
    load_data     <= '0;
    retire_ready  <= 1'b0;
    errors        = 0;
    checked       = 0;
    total_retires = 0;
    running       = 1'b0;

    // random back-pressure low about one cycle in four
    fork
      forever begin
        @(posedge clk);
        retire_ready <= rstn && ($urandom % 4 != 0);
      end
    join_none

    read_tests();

    // preload while the core is held in reset
    foreach (load_addr_q[i]) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= load_addr_q[i];
      load_data <= load_data_q[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
    repeat (2) @(posedge clk);
    rstn    <= 1'b1;
    running = 1'b1;

    if (total_retires == 0 || exp_pc_q.size() != total_retires) begin
      errors++;
      $display("fetch_tests.txt lists %0d expected retires but its tests count %0d",
               exp_pc_q.size(), total_retires);
    end else begin
      idx = 0;
      foreach (test_name_q[t]) begin
        test_errors = errors;
        for (k = 0; k < test_len_q[t]; k++) begin
          want_pc   = exp_pc_q[idx];
          want_inst = exp_inst_q[idx];
          next_retire(test_name_q[t], pc, inst);
          assert (pc === want_pc) else begin
            errors++;
            $display("error %0s: pc expected %h actual %h", test_name_q[t], want_pc, pc);
          end
          assert (inst === want_inst) else begin
            errors++;
            $display("error %0s: inst expected %h actual %h",
                     test_name_q[t], want_inst, inst);
          end
          assert (inst === image[want_pc[IDX_W+1:2]]) else begin
            errors++;
            $display("error %0s: word at %h expected %h actual %h",
                     test_name_q[t], want_pc, image[want_pc[IDX_W+1:2]], inst);
          end
          // the first fetch comes from the reset pc and later ones follow the previous retire
          if (idx == 0) begin
            rule_pc = `FETCH_RESET_PC;
          end else begin
            rule_pc = expected_next_pc(prev_pc, prev_inst);
          end
          assert (pc === rule_pc) else begin
            errors++;
            $display("error %0s: next pc expected %h actual %h", test_name_q[t], rule_pc, pc);
          end
          prev_pc   = want_pc;
          prev_inst = want_inst;
          checked++;
          idx++;
        end
        $display("test %0s: %0d retires, %0d errors",
                 test_name_q[t], test_len_q[t], errors - test_errors);
      end
    end

    $display("%0d tests, %0d retires checked, %0d errors",
             test_name_q.size(), checked, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // stall guard sized from the expected retire count
  initial begin
    longint limit;
    wait (running);
    limit = (longint'(total_retires) * (`IMEM_LAT_MAX + 8) + SLACK) * CLK_PERIOD;
    #(limit);
    $display("retire stream stalled, run not done after %0d cycles", limit / CLK_PERIOD);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
